/* include/dual_crc_consts.svh */
`ifndef DUAL_CRC_CONSTS_SVH
`define DUAL_CRC_CONSTS_SVH

// width of one link data word
`define CRC_DATA_W 32

// remainder width, both engines
`define CRC_W 16

// x^16 + x^12 + x^5 + 1, x^16 term implied
`define CRC_POLY_CCITT 16'h1021

// x^16 + x^15 + x^2 + 1, x^16 term implied
`define CRC_POLY_ANSI 16'h8005

// one serial step per data bit
`define CRC_SHIFTS `CRC_DATA_W

`endif

/* logic/dual_crc_pkg.sv */
`include "dual_crc_consts.svh"

package dual_crc_pkg;

	// one word as seen on the link
	typedef logic [`CRC_DATA_W-1:0] data_word_t;

	typedef logic [`CRC_W-1:0] crc_word_t;	// remainder of one polynomial

	// expected ccitt value in the upper half, ansi value in the lower half
	typedef logic [2*`CRC_W-1:0] check_field_t;

	// serial engine states
	typedef enum logic [1:0] {
		CRC_IDLE,	// waiting for launch
		CRC_SHIFT,	// one data bit per clock
		CRC_FINISH	// done cycle, remainder held
	} crc_state_t;

endpackage

/* logic/crc_serial_engine.sv */
`timescale 1ns/100ps
`include "dual_crc_consts.svh"

module crc_serial_engine
	import dual_crc_pkg::*;
#(
	parameter crc_word_t poly = `CRC_POLY_CCITT	// generator, x^16 term implied
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       launch,	// restarts the engine in any state
	input  data_word_t launch_data,
	output logic       done,	// one cycle after the last step
	output crc_word_t  remainder	// held until the next launch
);

	localparam int CNT_W = $clog2(`CRC_SHIFTS + 1);

	crc_state_t       state;
	data_word_t       shreg;	// bits still to go, msb first
	crc_word_t        rem_q;	// running remainder
	logic [CNT_W-1:0] step_cnt;	// steps already taken

	crc_word_t        rem_src;	// remainder entering this step
	logic             bit_src;	// data bit entering this step
	logic             fb;	// bit leaving the top of the divisor window
	crc_word_t        rem_next;
	logic             last_step;

	// a launch edge is also the first step, on a zero remainder
	always_comb begin
		if (launch) begin
			rem_src = '0;
			bit_src = launch_data[`CRC_DATA_W-1];	// msb goes in first
		end else begin
			rem_src = rem_q;
			bit_src = shreg[`CRC_DATA_W-1];
		end
	end

	// direct form of the long division: feeding the data bit in at the
	// top is the same as dividing data followed by sixteen zeros, so
	// 32 steps are enough instead of 48
	assign fb = rem_src[`CRC_W-1] ^ bit_src;
	assign rem_next = {rem_src[`CRC_W-2:0], 1'b0} ^ (poly & {`CRC_W{fb}});	// shift, xor if one

	assign last_step = (step_cnt == CNT_W'(`CRC_SHIFTS - 1));	// this edge does step 32

	// control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= CRC_IDLE;
			rem_q    <= '0;
			step_cnt <= '0;
		end else begin
			if (launch) begin
				rem_q    <= rem_next;	// first bit done on the launch edge
				step_cnt <= CNT_W'(1);
				state    <= CRC_SHIFT;
			end else begin
				case (state)
					CRC_SHIFT: begin
						rem_q    <= rem_next;
						step_cnt <= step_cnt + 1'b1;
						if (last_step) begin
							state <= CRC_FINISH;	// done goes high next cycle
						end
					end
					CRC_FINISH: begin
						state    <= CRC_IDLE;	// remainder stays put
						step_cnt <= '0;
					end
					default: begin
						state <= CRC_IDLE;
					end
				endcase
			end
		end
	end

	// data shift register, payload only
	always_ff @(posedge clk) begin
		if (launch) begin
			shreg <= launch_data << 1;	// msb already consumed
		end else if (state == CRC_SHIFT) begin
			shreg <= shreg << 1;
		end
	end

	assign done      = (state == CRC_FINISH);	// single cycle by construction
	assign remainder = rem_q;

endmodule

/* logic/crc_check_ctrl.sv */
`timescale 1ns/100ps
`include "dual_crc_consts.svh"

module crc_check_ctrl
	import dual_crc_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,	// pulse, ignored while busy
	input  data_word_t   data_in,
	input  check_field_t check_in,
	output logic         launch,	// pulse to both engines
	output data_word_t   launch_data,
	input  logic         done_a,
	input  crc_word_t    rem_a,
	input  logic         done_b,
	input  crc_word_t    rem_b,
	output logic         busy,
	output logic         result_valid,	// pulse, 33 cycles after start
	output crc_word_t    crc_a,
	output crc_word_t    crc_b,
	output logic         match_a,
	output logic         match_b,
	output logic         word_ok
);

	data_word_t   data_q;	// word under check
	check_field_t check_q;	// received check field
	logic         seen_a;	// sticky done, engine a
	logic         seen_b;	// sticky done, engine b

	logic         accept;
	logic         got_a;
	logic         got_b;
	logic         all_done;
	crc_word_t    exp_a;
	crc_word_t    exp_b;
	logic         hit_a;
	logic         hit_b;

	assign accept   = start & ~busy;	// new word only when idle
	assign got_a    = seen_a | done_a;	// done this cycle or earlier
	assign got_b    = seen_b | done_b;
	assign all_done = busy & got_a & got_b;

	assign exp_a = check_q[2*`CRC_W-1:`CRC_W];	// upper half, ccitt
	assign exp_b = check_q[`CRC_W-1:0];	// lower half, ansi
	assign hit_a = (rem_a == exp_a);
	assign hit_b = (rem_b == exp_b);

	assign launch_data = data_q;	// stable from the launch cycle on

	// control and held results
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			launch       <= 1'b0;
			result_valid <= 1'b0;
			seen_a       <= 1'b0;
			seen_b       <= 1'b0;
			crc_a        <= '0;
			crc_b        <= '0;
			match_a      <= 1'b0;
			match_b      <= 1'b0;
			word_ok      <= 1'b0;
		end else begin
			launch       <= 1'b0;	// strobes default low
			result_valid <= 1'b0;
			if (accept) begin
				busy   <= 1'b1;
				launch <= 1'b1;
				seen_a <= 1'b0;
				seen_b <= 1'b0;
			end else if (all_done) begin
				// both engines in, verdict on this edge
				busy         <= 1'b0;
				result_valid <= 1'b1;
				crc_a        <= rem_a;
				crc_b        <= rem_b;
				match_a      <= hit_a;
				match_b      <= hit_b;
				word_ok      <= hit_a & hit_b;
			end else if (busy) begin
				if (done_a) begin
					seen_a <= 1'b1;
				end
				if (done_b) begin
					seen_b <= 1'b1;
				end
			end
		end
	end

	// payload capture on an accepted start only
	always_ff @(posedge clk) begin
		if (accept) begin
			data_q  <= data_in;
			check_q <= check_in;
		end
	end

endmodule

/* logic/dual_crc_top.sv */
`timescale 1ns/100ps
`include "dual_crc_consts.svh"

module dual_crc_top
	import dual_crc_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         start,
	input  data_word_t   data_in,
	input  check_field_t check_in,
	output logic         busy,
	output logic         result_valid,
	output crc_word_t    crc_a,	// ccitt remainder
	output crc_word_t    crc_b,	// ansi remainder
	output logic         match_a,
	output logic         match_b,
	output logic         word_ok
);

	logic       launch;	// shared by both engines
	data_word_t launch_data;
	logic       done_a;
	crc_word_t  rem_a;
	logic       done_b;
	crc_word_t  rem_b;

	// start filter, result gathering, verdict
	crc_check_ctrl i_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.data_in      (data_in),
		.check_in     (check_in),
		.launch       (launch),
		.launch_data  (launch_data),
		.done_a       (done_a),
		.rem_a        (rem_a),
		.done_b       (done_b),
		.rem_b        (rem_b),
		.busy         (busy),
		.result_valid (result_valid),
		.crc_a        (crc_a),
		.crc_b        (crc_b),
		.match_a      (match_a),
		.match_b      (match_b),
		.word_ok      (word_ok)
	);

	// engine a, ccitt
	crc_serial_engine #(
		.poly (`CRC_POLY_CCITT)
	) i_crc_a (
		.clk         (clk),
		.rst_n       (rst_n),
		.launch      (launch),
		.launch_data (launch_data),
		.done        (done_a),
		.remainder   (rem_a)
	);

	// engine b, ansi
	crc_serial_engine #(
		.poly (`CRC_POLY_ANSI)
	) i_crc_b (
		.clk         (clk),
		.rst_n       (rst_n),
		.launch      (launch),
		.launch_data (launch_data),
		.done        (done_b),
		.remainder   (rem_b)
	);

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter real period_ns = 10.0	// full clock period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(period_ns / 2.0) clk = ~clk;	// free running, 50 % duty

endmodule

/* verif/dual_crc_properties.sv */
`timescale 1ns/100ps
`include "dual_crc_consts.svh"

module dual_crc_properties (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic busy,
	input logic result_valid
);

	localparam int VALID_LAT = `CRC_SHIFTS + 1;	// start edge to the edge that sets valid

	// valid is a single cycle strobe
	valid_single_cycle: assert property (
		@(posedge clk) disable iff (!rst_n)
		result_valid |=> !result_valid
	) else $error("result_valid high on two consecutive cycles");

	// pulse is set by edge E+33, so it is first sampled high one edge later
	start_to_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		(start && !busy) |-> ##(VALID_LAT + 1) result_valid
	) else $error("accepted start not followed by result_valid after 33 cycles");

	// checker comes out of reset idle
	idle_after_reset: assert property (
		@(posedge clk)
		$rose(rst_n) |-> !busy
	) else $error("busy high right after reset release");

endmodule

// attach to every instance of the top level
bind dual_crc_top dual_crc_properties i_props (
	.clk          (clk),
	.rst_n        (rst_n),
	.start        (start),
	.busy         (busy),
	.result_valid (result_valid)
);

/* verif/dual_crc_tb.sv */
`timescale 1ns/100ps
`include "dual_crc_consts.svh"

module dual_crc_tb
	import dual_crc_pkg::*;
;

	localparam int WAIT_LIMIT   = 200;	// cycles any wait may take
	localparam int RAND_WORDS   = 24;
	localparam int FLIP_WORDS   = 24;
	localparam int QUIET_CYCLES = 60;	// window for stray valids at the end
	localparam int EXP_LATENCY  = 33;

	logic         clk;
	logic         rst_n;
	logic         start;
	data_word_t   data_in;
	check_field_t check_in;
	logic         busy;
	logic         result_valid;
	crc_word_t    crc_a;
	crc_word_t    crc_b;
	logic         match_a;
	logic         match_b;
	logic         word_ok;

	logic [31:0]  rng_state = 32'd11513;	// lcg seed
	int           cycle_cnt = 0;
	int           results_seen = 0;	// valids seen by the compare process
	int           checks = 0;
	int           value_errs = 0;
	int           other_errs = 0;

	// expectations, one entry per accepted start
	crc_word_t    q_crc_a[$];
	crc_word_t    q_crc_b[$];
	logic         q_match_a[$];
	logic         q_match_b[$];
	int           q_start_cyc[$];

	tb_clock_gen #(.period_ns(10.0)) i_clk_gen (.clk(clk));

	dual_crc_top i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.data_in      (data_in),
		.check_in     (check_in),
		.busy         (busy),
		.result_valid (result_valid),
		.crc_a        (crc_a),
		.crc_b        (crc_b),
		.match_a      (match_a),
		.match_b      (match_b),
		.word_ok      (word_ok)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;	// read only away from the edge
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper halves only, low lcg bits are weak
	function automatic data_word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = next_rand();
		lo = next_rand();
		return {hi[31:16], lo[31:16]};
	endfunction

	// textbook long division of data followed by sixteen zeros
	function automatic crc_word_t crc_ref(input data_word_t data, input crc_word_t poly);
		logic [`CRC_DATA_W+`CRC_W-1:0] msg;
		crc_word_t rem;
		logic top;
		int i;
		msg = {data, {`CRC_W{1'b0}}};	// augmented message
		rem = '0;
		for (i = `CRC_DATA_W + `CRC_W - 1; i >= 0; i--) begin
			top = rem[`CRC_W-1];	// x^16 term about to appear
			rem = {rem[`CRC_W-2:0], msg[i]};
			if (top) begin
				rem = rem ^ poly;
			end
		end
		return rem;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("ERROR at time %0t: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
			value_errs++;
		end
	endtask

	task automatic close_run();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
		other_errs++;
		close_run();
	endtask

	// called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic issue_expect(input data_word_t data, input check_field_t check,
			input crc_word_t exp_a, input crc_word_t exp_b);
		int n;
		n = 0;
		while (busy && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (busy) begin
			stop_on_timeout("busy to drop before a start");
		end else begin
			start    = 1'b1;
			data_in  = data;
			check_in = check;
			q_crc_a.push_back(exp_a);
			q_crc_b.push_back(exp_b);
			q_match_a.push_back(check[2*`CRC_W-1:`CRC_W] == exp_a);	// upper half, ccitt
			q_match_b.push_back(check[`CRC_W-1:0] == exp_b);
			q_start_cyc.push_back(cycle_cnt + 1);	// edge that accepts it
			@(posedge clk);
			#1;
			start = 1'b0;
		end
	endtask

	task automatic wait_for_results(input int target);
		int n;
		n = 0;
		while (results_seen < target && n < WAIT_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (results_seen < target) begin
			stop_on_timeout("result_valid");
		end
	endtask

	// compare process, samples mid cycle
	always @(negedge clk) begin : compare_proc
		crc_word_t ea;
		crc_word_t eb;
		logic      ma;
		logic      mb;
		int        sc;
		if (rst_n && result_valid) begin
			if (q_crc_a.size() == 0) begin
				$display("result_valid at time %0t with no accepted word outstanding",
					$time);
				other_errs++;
			end else begin
				ea = q_crc_a.pop_front();
				eb = q_crc_b.pop_front();
				ma = q_match_a.pop_front();
				mb = q_match_b.pop_front();
				sc = q_start_cyc.pop_front();
				compare_field("crc_a", 32'(ea), 32'(crc_a));
				compare_field("crc_b", 32'(eb), 32'(crc_b));
				compare_field("match_a", 32'(ma), 32'(match_a));
				compare_field("match_b", 32'(mb), 32'(match_b));
				compare_field("word_ok", 32'(ma & mb), 32'(word_ok));
				compare_field("busy", 32'd0, 32'(busy));	// drops with the verdict
				compare_field("result_valid latency", 32'(EXP_LATENCY),
					32'(cycle_cnt - sc));
			end
			results_seen++;
		end
	end

	initial begin : stimulus
		data_word_t   d;
		check_field_t c;
		crc_word_t    ra;
		crc_word_t    rb;
		int           k;
		int           issued;
		rst_n    = 1'b0;
		start    = 1'b0;
		data_in  = '0;
		check_in = '0;
		issued   = 0;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		#1;

		// idle, everything cleared
		compare_field("busy", 32'd0, 32'(busy));
		compare_field("result_valid", 32'd0, 32'(result_valid));
		compare_field("crc_a", 32'd0, 32'(crc_a));
		compare_field("crc_b", 32'd0, 32'(crc_b));
		compare_field("match_a", 32'd0, 32'(match_a));
		compare_field("match_b", 32'd0, 32'(match_b));
		compare_field("word_ok", 32'd0, 32'(word_ok));

		// known vectors, x^16 mod p is p itself
		issue_expect(32'h0000_0000, 32'h0000_0000, 16'h0000, 16'h0000);
		issued++;
		wait_for_results(issued);
		issue_expect(32'h0000_0001, {16'h1021, 16'h8005}, 16'h1021, 16'h8005);
		issued++;
		wait_for_results(issued);

		// random words, correct check field
		for (k = 0; k < RAND_WORDS; k++) begin
			d  = rand_word();
			ra = crc_ref(d, `CRC_POLY_CCITT);
			rb = crc_ref(d, `CRC_POLY_ANSI);
			issue_expect(d, {ra, rb}, ra, rb);
			issued++;
			wait_for_results(issued);
		end

		// one bit of the check field flipped
		for (k = 0; k < FLIP_WORDS; k++) begin
			d  = rand_word();
			ra = crc_ref(d, `CRC_POLY_CCITT);
			rb = crc_ref(d, `CRC_POLY_ANSI);
			c  = {ra, rb} ^ (32'h1 << (next_rand() >> 27));	// top five bits pick the flip
			issue_expect(d, c, ra, rb);
			issued++;
			wait_for_results(issued);
		end

		// starts while busy must be dropped
		d  = rand_word();
		ra = crc_ref(d, `CRC_POLY_CCITT);
		rb = crc_ref(d, `CRC_POLY_ANSI);
		c  = {ra, rb};
		issue_expect(d, c, ra, rb);
		issued++;
		repeat (4) @(posedge clk);
		#1;
		for (k = 0; k < 3; k++) begin
			if (!busy) begin
				$display("busy low at time %0t while a word is running", $time);
				other_errs++;
			end
			start    = 1'b1;
			data_in  = ~d;	// would give other crcs if taken
			check_in = ~c;
			@(posedge clk);
			#1;
		end
		start = 1'b0;
		wait_for_results(issued);

		// stray valids show up in the compare process
		repeat (QUIET_CYCLES) @(posedge clk);
		#1;
		if (q_crc_a.size() != 0) begin
			$display("%0d accepted words never produced a result", q_crc_a.size());
			other_errs++;
		end
		close_run();
	end

endmodule

/* dual_crc.f */
+incdir+include
logic/dual_crc_pkg.sv
logic/crc_serial_engine.sv
logic/crc_check_ctrl.sv
logic/dual_crc_top.sv
verif/tb_clock_gen.sv
verif/dual_crc_properties.sv
verif/dual_crc_tb.sv

/* Makefile */
# Verilator flow for the dual CRC-16 word checker
# every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= dual_crc_tb
FILELIST  ?= dual_crc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
